// File: src.f
src/zap_bus_pkg.sv
src/zap_bus_arbiter_fsm.sv
src/zap_bus_watchdog.sv
src/zap_bus_request_mux.sv
src/zap_bus_top.sv
+incdir+verification
verification/tb_zap_bus_top.sv

// File: Bender.yml
package:
  name: zap_bus

sources:
  - files:
      - src/zap_bus_pkg.sv
      - src/zap_bus_arbiter_fsm.sv
      - src/zap_bus_watchdog.sv
      - src/zap_bus_request_mux.sv
      - src/zap_bus_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_zap_bus_top.sv

// File: verification/zap_bus_ref.svh
`ifndef ZAP_BUS_REF_SVH
`define ZAP_BUS_REF_SVH

// ------------------------------
// Reference bus model.
// ------------------------------

// Request seen on the bus for a code or a data grant.
function automatic zap_bus_pkg::wb_req_t expected_bus_req
(
        input logic                 is_code,
        input logic [31:0]          instr_adr,
        input zap_bus_pkg::wb_req_t data_req,
        input logic [6:0]           pid,
        input logic                 be32
);
        zap_bus_pkg::wb_req_t req;
        logic [31:0]          base;

        if (is_code)
        begin
                base    = instr_adr & 32'hffff_fffc;    // Word aligned fetch.
                req.we  = 1'b0;
                req.sel = 4'hf;
                req.dat = 32'h0;
        end
        else
        begin
                base    = data_req.adr;
                req.we  = data_req.we;
                req.sel = be32 ? {data_req.sel[0], data_req.sel[1], data_req.sel[2], data_req.sel[3]}
                               : data_req.sel;
                req.dat = data_req.dat;
        end
        req.adr = base + {pid, 25'd0};  // Carry out of bit 31 is lost.
        return req;
endfunction

// Read data as the core port receives it.
function automatic logic [31:0] expected_read_data
(
        input logic        to_data,
        input logic [31:0] bus_dat,
        input logic        be32
);
        if (to_data && be32)
                return {bus_dat[7:0], bus_dat[15:8], bus_dat[23:16], bus_dat[31:24]};
        return bus_dat;
endfunction

`endif

// File: verification/tb_zap_bus_top.sv
`timescale 1ns/1ps

module tb_zap_bus_top;

import zap_bus_pkg::*;

`include "zap_bus_ref.svh"

localparam int unsigned MAX_WAIT   = 6;     // Slave waits 0 to 5 cycles.
localparam int unsigned DONE_LIMIT = 100;   // Cycles allowed per transfer.
localparam int unsigned DRIVE_SKEW = 2;

logic              i_clk, i_arst_n;
logic              i_instr_stb, i_data_stb, i_be32_en, i_wb_ack;
logic [ADDR_W-1:0] i_instr_adr, o_wb_adr;
logic [PID_W-1:0]  i_pid;
logic [DATA_W-1:0] i_wb_dat, o_wb_dat;
logic [SEL_W-1:0]  o_wb_sel;
logic              o_wb_cyc, o_wb_stb, o_wb_we;
logic [2:0]        o_wb_cti;
logic [1:0]        o_wb_bte;
wb_req_t           i_data_req;
wb_rsp_t           o_instr_rsp, o_data_rsp;

string             test_name;
int unsigned       value_errors, other_errors, bus_cycles, cyc_len;
logic              hold_ack;     // Slave never acks.
logic              got_err;
logic              exp_code, last_data;

zap_bus_top UUT (.*);

initial
begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
end

// ------------------------------
// Slave model.
// ------------------------------

initial
begin : slave_model
        int unsigned wait_left;
        logic        busy;

        wait_left = 0;
        busy      = 1'b0;
        i_wb_ack  = 1'b0;
        i_wb_dat  = '0;
        forever
        begin
                @(posedge i_clk);
                #DRIVE_SKEW;
                i_wb_ack = 1'b0;
                if (!o_wb_cyc)
                        busy = 1'b0;
                else
                begin
                        if (!busy)
                        begin
                                busy      = 1'b1;
                                wait_left = $urandom % MAX_WAIT;
                        end
                        if (wait_left == 0 && !hold_ack)
                        begin
                                i_wb_ack = 1'b1;
                                i_wb_dat = $urandom;
                        end
                        else if (wait_left != 0)
                                wait_left--;
                end
        end
end

task automatic report_value(input string what, input logic [68:0] exp, input logic [68:0] act);
        value_errors++;
        $display("** Error %s, %s: expected %h, actual %h", test_name, what, exp, act);
endtask

// ------------------------------
// Checking process.
// ------------------------------

always @(negedge i_clk)
begin : compare
        wb_req_t exp_req;
        wb_req_t act_req;
        wb_rsp_t exp_rsp;
        wb_rsp_t act_rsp;
        wb_rsp_t idle_rsp;

        if (!i_arst_n)
        begin
                cyc_len   = 0;
                last_data = 1'b0;   // Data first after reset.
        end
        else if (o_wb_cyc)
        begin
                if (cyc_len == 0)
                begin
                        exp_code  = (i_instr_stb && i_data_stb) ? last_data : !i_data_stb;
                        last_data = !exp_code;
                        bus_cycles++;
                end
                cyc_len++;
                exp_req = expected_bus_req(exp_code, i_instr_adr, i_data_req, i_pid, i_be32_en);
                act_req = {o_wb_adr, o_wb_we, o_wb_sel, o_wb_dat};
                assert (act_req == exp_req && o_wb_stb)
                else report_value("bus request", exp_req, act_req);

                exp_rsp.ack = i_wb_ack;
                exp_rsp.err = !i_wb_ack && (cyc_len == WB_TIMEOUT_CYCLES);
                exp_rsp.dat = expected_read_data(!exp_code, i_wb_dat, i_be32_en);
                act_rsp     = exp_code ? o_instr_rsp : o_data_rsp;
                idle_rsp    = exp_code ? o_data_rsp : o_instr_rsp;
                if (!i_wb_ack)
                        act_rsp.dat = exp_rsp.dat;  // Data only counts with ack.
                assert (act_rsp == exp_rsp) else report_value("response", exp_rsp, act_rsp);
                assert (!idle_rsp.ack && !idle_rsp.err)
                else report_value("other port", 2'b00, {idle_rsp.ack, idle_rsp.err});
        end
        else
        begin
                cyc_len = 0;
                assert (!o_wb_stb && !o_instr_rsp.ack && !o_instr_rsp.err &&
                        !o_data_rsp.ack && !o_data_rsp.err)
                else report_value("idle bus", 5'b0, {o_wb_stb, o_instr_rsp.ack,
                                  o_instr_rsp.err, o_data_rsp.ack, o_data_rsp.err});
        end
        assert (o_wb_cti == WB_CTI_EOB && o_wb_bte == WB_BTE_LINEAR)
        else report_value("burst codes", {WB_CTI_EOB, WB_BTE_LINEAR}, {o_wb_cti, o_wb_bte});
end

// ------------------------------
// Core-side stimulus.
// ------------------------------

task automatic apply_reset();
        @(posedge i_clk);
        #DRIVE_SKEW;
        i_arst_n = 1'b0;
        repeat (5) @(posedge i_clk);
        #DRIVE_SKEW;
        i_arst_n = 1'b1;
endtask

task automatic pick_request();
        i_instr_adr    = $urandom;
        i_data_req.adr = i_instr_adr ^ 32'h0000_1000;   // Keeps the ports apart.
        i_data_req.we  = $urandom_range(0, 1);
        i_data_req.sel = $urandom;
        i_data_req.dat = $urandom;
        i_pid          = $urandom;
endtask

// Counts ack or err returns on either port until enough have come.
task automatic wait_done(input int unsigned count);
        int unsigned seen;
        int unsigned cycles;

        seen   = 0;
        cycles = 0;
        while (seen < count && cycles < DONE_LIMIT * count)
        begin
                @(negedge i_clk);
                cycles++;
                if (o_instr_rsp.ack || o_instr_rsp.err || o_data_rsp.ack || o_data_rsp.err)
                        seen++;
                if (o_instr_rsp.err || o_data_rsp.err)
                        got_err = 1'b1;
        end
        assert (seen == count)
        else
        begin
                other_errors++;
                $display("%s: only %0d of %0d transfers finished in time", test_name, seen, count);
        end
endtask

task automatic transfer(input logic is_code);
        @(posedge i_clk);
        #DRIVE_SKEW;
        pick_request();
        i_instr_stb = is_code;
        i_data_stb  = !is_code;
        wait_done(1);
        @(posedge i_clk);
        #DRIVE_SKEW;
        i_instr_stb = 1'b0;
        i_data_stb  = 1'b0;
endtask

initial
begin
        void'($urandom(25));
        i_arst_n     = 1'b0;
        i_instr_stb  = 1'b0;
        i_data_stb   = 1'b0;
        i_instr_adr  = '0;
        i_data_req   = '0;
        i_pid        = '0;
        i_be32_en    = 1'b0;
        hold_ack     = 1'b0;
        got_err      = 1'b0;
        value_errors = 0;
        other_errors = 0;
        bus_cycles   = 0;
        test_name    = "reset";
        apply_reset();
        @(negedge i_clk);
        assert (!o_wb_cyc) else report_value("o_wb_cyc", 1'b0, o_wb_cyc);

        test_name = "code fetch";
        repeat (8) transfer(1'b1);
        test_name = "data be32 off";
        repeat (8) transfer(1'b0);
        test_name = "data be32 on";
        i_be32_en = 1'b1;
        repeat (8) transfer(1'b0);
        i_be32_en = 1'b0;

        test_name = "both strobes";
        apply_reset();
        @(posedge i_clk);
        #DRIVE_SKEW;
        pick_request();
        i_instr_stb = 1'b1;
        i_data_stb  = 1'b1;
        wait_done(8);
        @(posedge i_clk);
        #DRIVE_SKEW;
        i_instr_stb = 1'b0;
        i_data_stb  = 1'b0;

        test_name = "watchdog";
        hold_ack  = 1'b1;
        got_err   = 1'b0;
        transfer(1'b0);
        hold_ack  = 1'b0;
        assert (got_err)
        else
        begin
                other_errors++;
                $display("watchdog: the data port never saw an error return");
        end
        @(negedge i_clk);
        assert (!o_wb_cyc) else report_value("o_wb_cyc", 1'b0, o_wb_cyc);
        test_name = "after watchdog";
        transfer(1'b0);

        repeat (2) @(posedge i_clk);
        $display("Done: %0d value errors, %0d other errors, %0d bus cycles",
                 value_errors, other_errors, bus_cycles);
        if (value_errors == 0 && other_errors == 0)
                $display("RESULT: PASS");
        else
                $display("RESULT: FAIL");
        $finish;
end

endmodule

// File: src/zap_bus_top.sv
`timescale 1ns/1ps

module zap_bus_top
(
        // ------------------------------
        // Clock and reset.
        // ------------------------------

        input   logic                            i_clk,
        input   logic                            i_arst_n,

        // ------------------------------
        // Core code port.
        // ------------------------------

        input   logic                            i_instr_stb,
        input   logic [zap_bus_pkg::ADDR_W-1:0]  i_instr_adr,
        output  zap_bus_pkg::wb_rsp_t            o_instr_rsp,

        // ------------------------------
        // Core data port.
        // ------------------------------

        input   logic                            i_data_stb,
        input   zap_bus_pkg::wb_req_t            i_data_req,
        output  zap_bus_pkg::wb_rsp_t            o_data_rsp,

        // ------------------------------
        // Control levels.
        // ------------------------------

        input   logic [zap_bus_pkg::PID_W-1:0]   i_pid,
        input   logic                            i_be32_en,

        // ------------------------------
        // Wishbone master.
        // ------------------------------

        output  logic                            o_wb_cyc,
        output  logic                            o_wb_stb,
        output  logic [zap_bus_pkg::ADDR_W-1:0]  o_wb_adr,
        output  logic                            o_wb_we,
        output  logic [zap_bus_pkg::SEL_W-1:0]   o_wb_sel,
        output  logic [zap_bus_pkg::DATA_W-1:0]  o_wb_dat,
        output  logic [2:0]                      o_wb_cti,
        output  logic [1:0]                      o_wb_bte,
        input   logic                            i_wb_ack,
        input   logic [zap_bus_pkg::DATA_W-1:0]  i_wb_dat
);

import zap_bus_pkg::*;

arb_state_e state;
logic       bus_active;
logic       timeout;
wb_req_t    wb_req;

zap_bus_arbiter_fsm u_arbiter (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_instr_stb    (i_instr_stb),
        .i_data_stb     (i_data_stb),
        .i_wb_ack       (i_wb_ack),
        .i_timeout      (timeout),
        .o_state        (state),
        .o_bus_active   (bus_active)
);

zap_bus_watchdog u_watchdog (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_bus_active   (bus_active),
        .i_wb_ack       (i_wb_ack),
        .o_timeout      (timeout)
);

zap_bus_request_mux u_request_mux (
        .i_state        (state),
        .i_bus_active   (bus_active),
        .i_instr_adr    (i_instr_adr),
        .i_data_req     (i_data_req),
        .i_pid          (i_pid),
        .i_be32_en      (i_be32_en),
        .i_wb_ack       (i_wb_ack),
        .i_timeout      (timeout),
        .i_wb_dat       (i_wb_dat),
        .o_instr_rsp    (o_instr_rsp),
        .o_data_rsp     (o_data_rsp),
        .o_wb_req       (wb_req),
        .o_wb_cyc       (o_wb_cyc),
        .o_wb_stb       (o_wb_stb),
        .o_wb_cti       (o_wb_cti),
        .o_wb_bte       (o_wb_bte)
);

// Flatten the request onto the bus pins.
assign o_wb_adr = wb_req.adr;
assign o_wb_we  = wb_req.we;
assign o_wb_sel = wb_req.sel;
assign o_wb_dat = wb_req.dat;

endmodule

// File: src/zap_bus_request_mux.sv
`timescale 1ns/1ps

module zap_bus_request_mux
(
        // ------------------------------
        // Grant.
        // ------------------------------

        input   zap_bus_pkg::arb_state_e         i_state,
        input   logic                            i_bus_active,

        // ------------------------------
        // Core requests.
        // ------------------------------

        input   logic [zap_bus_pkg::ADDR_W-1:0]  i_instr_adr,
        input   zap_bus_pkg::wb_req_t            i_data_req,
        input   logic [zap_bus_pkg::PID_W-1:0]   i_pid,
        input   logic                            i_be32_en,

        // ------------------------------
        // Bus returns.
        // ------------------------------

        input   logic                            i_wb_ack,
        input   logic                            i_timeout,
        input   logic [zap_bus_pkg::DATA_W-1:0]  i_wb_dat,

        output  zap_bus_pkg::wb_rsp_t            o_instr_rsp,
        output  zap_bus_pkg::wb_rsp_t            o_data_rsp,

        output  zap_bus_pkg::wb_req_t            o_wb_req,
        output  logic                            o_wb_cyc,
        output  logic                            o_wb_stb,
        output  logic [2:0]                      o_wb_cti,
        output  logic [1:0]                      o_wb_bte
);

import zap_bus_pkg::*;

// Mirror select bits for BE-32.
function automatic logic [SEL_W-1:0] rev_sel(input logic [SEL_W-1:0] sel);
        logic [SEL_W-1:0] r;
        for (int i = 0; i < SEL_W; i++)
        begin
                r[i] = sel[SEL_W-1-i];
        end
        return r;
endfunction

// Mirror byte lanes for BE-32.
function automatic logic [DATA_W-1:0] rev_bytes(input logic [DATA_W-1:0] dat);
        logic [DATA_W-1:0] r;
        for (int i = 0; i < SEL_W; i++)
        begin
                r[8*i +: 8] = dat[8*(SEL_W-1-i) +: 8];
        end
        return r;
endfunction

wb_req_t           req_sel;     // Granted request before relocation.
logic [ADDR_W-1:0] pid_offset;
logic              instr_grant, data_grant;

assign pid_offset  = ADDR_W'(i_pid) << PID_SHIFT;
assign instr_grant = (i_state == ARB_CODE);
assign data_grant  = (i_state == ARB_DATA);

// ------------------------------
// Request path.
// ------------------------------

always_comb
begin
        case (i_state)
        ARB_CODE:
        begin
                req_sel.adr = {i_instr_adr[ADDR_W-1:2], 2'b00}; // Word aligned fetch.
                req_sel.we  = 1'b0;
                req_sel.sel = '1;
                req_sel.dat = '0;
        end
        ARB_DATA:
        begin
                req_sel = i_data_req;
                if (i_be32_en)
                        req_sel.sel = rev_sel(i_data_req.sel);
        end
        default: req_sel = '0;
        endcase
end

always_comb
begin
        o_wb_req     = req_sel;
        o_wb_req.adr = req_sel.adr + pid_offset; // Wraps modulo 2^32.
end

assign o_wb_cyc = i_bus_active;
assign o_wb_stb = i_bus_active;
assign o_wb_cti = WB_CTI_EOB;     // Every transfer is a single classic cycle.
assign o_wb_bte = WB_BTE_LINEAR;

// ------------------------------
// Response path.
// ------------------------------

always_comb
begin
        o_instr_rsp.ack = instr_grant && i_wb_ack;
        o_instr_rsp.err = instr_grant && i_timeout;
        o_instr_rsp.dat = i_wb_dat;

        o_data_rsp.ack  = data_grant && i_wb_ack;
        o_data_rsp.err  = data_grant && i_timeout;
        o_data_rsp.dat  = i_be32_en ? rev_bytes(i_wb_dat) : i_wb_dat;
end

// Watchdog and slave must never close the same cycle twice.
always_comb
begin
        a_rsp_exclusive : assert final (!(o_instr_rsp.ack && o_instr_rsp.err) &&
                                        !(o_data_rsp.ack && o_data_rsp.err));
end

endmodule

// File: src/zap_bus_watchdog.sv
`timescale 1ns/1ps

module zap_bus_watchdog
(
        // ------------------------------
        // Clock and reset.
        // ------------------------------

        input   logic   i_clk,
        input   logic   i_arst_n,

        // ------------------------------
        // Bus status.
        // ------------------------------

        input   logic   i_bus_active,
        input   logic   i_wb_ack,

        output  logic   o_timeout
);

import zap_bus_pkg::*;

localparam logic [WB_TIMEOUT_W-1:0] LIMIT = WB_TIMEOUT_W'(WB_TIMEOUT_CYCLES - 1);

logic [WB_TIMEOUT_W-1:0] wait_cnt; // Active cycles seen without ack.

// Fires in the last allowed wait cycle. A late ack still wins.
assign o_timeout = i_bus_active && !i_wb_ack && (wait_cnt == LIMIT);

always_ff @(posedge i_clk or negedge i_arst_n)
begin
        if (!i_arst_n)
                wait_cnt <= '0;
        else if (!i_bus_active || i_wb_ack || o_timeout)
                wait_cnt <= '0;  // Restart for the next cycle.
        else
                wait_cnt <= wait_cnt + 1'b1;
end

// The arbiter drops the grant right after a timeout, so it cannot repeat.
a_timeout_pulse : assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        o_timeout |=> !i_bus_active
);

endmodule

// File: src/zap_bus_arbiter_fsm.sv
`timescale 1ns/1ps

module zap_bus_arbiter_fsm
(
        // ------------------------------
        // Clock and reset.
        // ------------------------------

        input   logic                   i_clk,
        input   logic                   i_arst_n,

        // ------------------------------
        // Requests and cycle end.
        // ------------------------------

        input   logic                   i_instr_stb,
        input   logic                   i_data_stb,
        input   logic                   i_wb_ack,
        input   logic                   i_timeout,

        // ------------------------------
        // Grant.
        // ------------------------------

        output  zap_bus_pkg::arb_state_e o_state,
        output  logic                   o_bus_active
);

import zap_bus_pkg::*;

arb_state_e state, state_nxt;
logic       last_was_data, last_was_data_nxt; // Low means code was served last.
logic       cycle_done;

assign cycle_done   = i_wb_ack || i_timeout;
assign o_state      = state;
assign o_bus_active = (state != ARB_IDLE);

// Next state and fairness flag.
always_comb
begin
        state_nxt         = state;
        last_was_data_nxt = last_was_data;

        case (state)
        ARB_IDLE:
        begin
                if (i_instr_stb && i_data_stb)
                begin
                        // Tie. Serve whoever waited last time.
                        state_nxt         = last_was_data ? ARB_CODE : ARB_DATA;
                        last_was_data_nxt = !last_was_data;
                end
                else if (i_data_stb)
                begin
                        state_nxt         = ARB_DATA;
                        last_was_data_nxt = 1'b1;
                end
                else if (i_instr_stb)
                begin
                        state_nxt         = ARB_CODE;
                        last_was_data_nxt = 1'b0;
                end
        end

        ARB_CODE, ARB_DATA:
        begin
                if (cycle_done)
                        state_nxt = ARB_IDLE; // Always one idle cycle between grants.
        end

        default: state_nxt = ARB_IDLE;
        endcase
end

always_ff @(posedge i_clk or negedge i_arst_n)
begin
        if (!i_arst_n)
        begin
                state         <= ARB_IDLE;
                last_was_data <= 1'b0;   // Data wins the first tie.
        end
        else
        begin
                state         <= state_nxt;
                last_was_data <= last_was_data_nxt;
        end
end

// A grant hands over only through idle.
a_no_direct_handover : assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        (state != ARB_IDLE) |=> (state == $past(state)) || (state == ARB_IDLE)
);

endmodule

// File: src/zap_bus_pkg.sv
package zap_bus_pkg;

// ------------------------------
// Bus widths.
// ------------------------------

localparam int unsigned ADDR_W    = 32;   // Wishbone address.
localparam int unsigned DATA_W    = 32;   // Wishbone data.
localparam int unsigned SEL_W     = 4;    // One select per byte lane.
localparam int unsigned PID_W     = 7;    // Process ID.
localparam int unsigned PID_SHIFT = 25;   // PID lands on bits 31:25.

// ------------------------------
// Watchdog.
// ------------------------------

localparam int unsigned WB_TIMEOUT_CYCLES = 16;   // Wait cycles before err.
localparam int unsigned WB_TIMEOUT_W      = $clog2(WB_TIMEOUT_CYCLES);

// ------------------------------
// Wishbone registered feedback codes.
// ------------------------------

localparam logic [2:0] WB_CTI_EOB    = 3'b111;    // End of burst.
localparam logic [1:0] WB_BTE_LINEAR = 2'b00;     // Linear burst.

// Request toward the bus.
typedef struct packed
{
        logic [ADDR_W-1:0] adr;
        logic              we;
        logic [SEL_W-1:0]  sel;
        logic [DATA_W-1:0] dat;
} wb_req_t;

// Response back to a core port.
typedef struct packed
{
        logic              ack;
        logic              err;
        logic [DATA_W-1:0] dat;
} wb_rsp_t;

// Arbiter states.
typedef enum logic [1:0]
{
        ARB_IDLE = 2'd0,
        ARB_CODE = 2'd1,
        ARB_DATA = 2'd2
} arb_state_e;

endpackage
